// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  # packages first, then the design from leaf to top
  - fetch_params_pkg.sv
  - fetch_bus_pkg.sv
  - pc_gen.sv
  - inst_rom.sv
  - fetch_stage.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_props.sv
      - fetch_tb.sv

// ==== fetch_bus_pkg.sv ====
// packed bus structs between decode, fetch and the instruction memory; import where a bus is used
`default_nettype none

package fetch_bus_pkg;

  import fetch_params_pkg::*;

  // decode -> fetch
  // stall holds fetch while decode waits on a hazard
  // sel redirects the next fetch to target
  typedef struct packed {
    logic             stall;
    logic             sel;
    logic [PC_WD-1:0] target;
  } br_bus_t;

  // fetch -> decode
  // inst sits in the upper bits, matching {inst, pc} of the older flat bus
  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_t;

  // pc_gen -> inst_rom
  // ren pulses together with the pc advance, addr is a doubleword index
  // of the pc being loaded, so data lines up with the new pc next cycle
  typedef struct packed {
    logic                   ren;
    logic [MEM_ADDR_WD-1:0] addr;
  } imem_req_t;

  // widths of the packed buses, handy for waveform and bus checks
  localparam int unsigned BR_BUS_WD       = $bits(br_bus_t);
  localparam int unsigned FS_TO_DS_BUS_WD = $bits(fs_to_ds_t);
  localparam int unsigned IMEM_REQ_WD     = $bits(imem_req_t);

endpackage : fetch_bus_pkg

`default_nettype wire

// ==== fetch_params_pkg.sv ====
// widths and reset vector for the fetch stage, imported by every RTL module and the testbench
`default_nettype none

package fetch_params_pkg;

  // datapath widths
  localparam int unsigned INST_WD     = 32; // one rv64 instruction, no compressed
  localparam int unsigned PC_WD       = 64;
  localparam int unsigned MEM_DATA_WD = 64; // one doubleword per memory read

  // doubleword index width, also the default depth exponent of the memory
  // a smaller depth is allowed, a larger one does not fit imem_req_t
  localparam int unsigned MEM_ADDR_WD = 10;

  // byte offset bits inside one memory word
  localparam int unsigned DW_OFFSET   = 3;

  // pc step for sequential fetch
  localparam int unsigned INST_BYTES  = 4;

  // first instruction fetched after reset, must be 4-byte aligned
  localparam logic [PC_WD-1:0] RESET_PC = 64'h0000_0000_8000_0000;

endpackage : fetch_params_pkg

`default_nettype wire

// ==== fetch_props.sv ====
// concurrent checks on the fetch-to-decode outputs, bound into fetch_top for simulation
`timescale 1ns/1ps
`default_nettype none

module fetch_props
  import fetch_params_pkg::*;
  import fetch_bus_pkg::*;
#(
  parameter int unsigned P_ADDR_WD = MEM_ADDR_WD
) (
  input logic                   i_clk,
  input logic                   i_arst_n,
  input br_bus_t                i_br_bus,
  input logic                   i_ds_allowin,
  input logic                   i_valid,
  input fs_to_ds_t              i_bus,
  // memory load port, watched to keep a shadow copy
  input logic                   i_we,
  input logic [P_ADDR_WD-1:0]   i_waddr,
  input logic [MEM_DATA_WD-1:0] i_wdata
);

  localparam int unsigned DEPTH = 2 ** P_ADDR_WD;

  int unsigned fail_cnt = 0; // polled by the testbench every cycle

  logic [MEM_DATA_WD-1:0] shadow [DEPTH]; // every doubleword written so far
  logic [P_ADDR_WD-1:0]   exp_idx;
  logic [MEM_DATA_WD-1:0] exp_word;
  logic [INST_WD-1:0]     exp_half;

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      shadow[i_waddr] <= i_wdata;
    end
  end

  assign exp_idx  = i_bus.pc[DW_OFFSET +: P_ADDR_WD];
  assign exp_word = shadow[exp_idx];

  // odd word of the doubleword lives in the upper half
  assign exp_half = i_bus.pc[2] ? exp_word[63:32] : exp_word[31:0];

  // decode holds off, so the item stays put
  a_hold_stable : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_valid && !i_ds_allowin |=> i_valid && $stable(i_bus))
    else begin
      $error("fetch bus moved while decode held it off");
      fail_cnt++;
    end

  // stage drains and stays empty during a stall
  a_stall_empty : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_br_bus.stall && (!i_valid || i_ds_allowin) |=> !i_valid)
    else begin
      $error("fetch stage filled while stalled");
      fail_cnt++;
    end

  a_accept : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !i_br_bus.stall && (!i_valid || i_ds_allowin) |=> i_valid)
    else begin
      $error("fetch stage did not take a new item");
      fail_cnt++;
    end

  a_inst_half : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_valid |-> i_bus.inst == exp_half)
    else begin
      $error("instruction does not match the loaded program at its pc");
      fail_cnt++;
    end

  a_pc_aligned : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_valid |-> i_bus.pc[1:0] == 2'b00)
    else begin
      $error("fetch pc not word aligned");
      fail_cnt++;
    end

endmodule : fetch_props

bind fetch_top fetch_props #(
  .P_ADDR_WD    (P_ADDR_WD       )
) u_fetch_props (
  .i_clk        (i_clk           ),
  .i_arst_n     (i_arst_n        ),
  .i_br_bus     (i_br_bus        ),
  .i_ds_allowin (i_ds_allowin    ),
  .i_valid      (o_fs_to_ds_valid),
  .i_bus        (o_fs_to_ds_bus  ),
  .i_we         (i_imem_we       ),
  .i_waddr      (i_imem_waddr    ),
  .i_wdata      (i_imem_wdata    )
);

`default_nettype wire

// ==== fetch_stage.sv ====
// fetch stage register with valid/allowin handshake and instruction half select, used in fetch_top
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import fetch_params_pkg::*;
  import fetch_bus_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // from decode
  input  br_bus_t                i_br_bus,
  input  logic                   i_ds_allowin,
  // from pc_gen and inst_rom
  input  logic [PC_WD-1:0]       i_pc,
  input  logic [MEM_DATA_WD-1:0] i_rdata,
  // pc advance strobe to pc_gen
  output logic                   o_load,
  // to decode
  output logic                   o_fs_to_ds_valid,
  output fs_to_ds_t              o_fs_to_ds_bus
);

  logic               fs_valid_q;
  logic               fs_allowin;
  logic               to_fs_valid;
  logic               br_stall;
  logic               br_sel;
  logic               pc_upper;
  logic [INST_WD-1:0] fs_inst;

  assign br_stall = i_br_bus.stall;
  assign br_sel   = i_br_bus.sel;

  // a new item is offered every cycle unless decode stalls us
  assign to_fs_valid = ~br_stall;

  // empty stage takes anything
  // a full one only when its item moves on into decode
  // every fetch completes in one cycle, so no ready_go term here
  assign fs_allowin = ~fs_valid_q | i_ds_allowin;

  // pc moves when an item is accepted or a branch redirects fetch
  assign o_load = br_sel | (to_fs_valid & fs_allowin);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fs_valid_q <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid_q <= to_fs_valid; // drains to empty under stall
    end
  end

  // memory returns an aligned doubleword
  // pc[2] picks the instruction inside it, upper half for the odd word
  assign pc_upper = i_pc[DW_OFFSET-1];

  always_comb begin
    if (pc_upper) begin
      fs_inst = i_rdata[INST_WD +: INST_WD];
    end else begin
      fs_inst = i_rdata[0 +: INST_WD];
    end
  end

  // pc and rdata both hold while no load happens, so the bus is stable
  // under back-pressure without an extra output register
  assign o_fs_to_ds_valid = fs_valid_q;

  always_comb begin
    o_fs_to_ds_bus      = '0;
    o_fs_to_ds_bus.inst = fs_inst;
    o_fs_to_ds_bus.pc   = i_pc;
  end

endmodule : fetch_stage

`default_nettype wire

// ==== fetch_tb.sv ====
// testbench for fetch_top, plays the decode stage with LFSR-driven allowin, stall and branches
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import fetch_params_pkg::*;
  import fetch_bus_pkg::*;
();

  localparam int unsigned TB_ADDR_WD      = 7; // 128 doublewords keeps the load phase short
  localparam int unsigned MEM_WORDS       = 2 ** TB_ADDR_WD;
  localparam int unsigned RESET_CYCLES    = 10;
  localparam int unsigned RUN_CYCLES      = 400;
  localparam int unsigned FIRST_TIMEOUT   = 20;
  localparam int unsigned IDLE_TIMEOUT    = 40;
  localparam int unsigned WATCHDOG_CYCLES = 2000;
  localparam logic [15:0] LFSR_SEED       = 16'd57;

  logic                   clk;
  logic                   arst_n;
  br_bus_t                br_bus;
  logic                   ds_allowin;
  logic                   imem_we;
  logic [TB_ADDR_WD-1:0]  imem_waddr;
  logic [MEM_DATA_WD-1:0] imem_wdata;
  logic                   fs_valid;
  fs_to_ds_t              fs_bus;

  logic [MEM_DATA_WD-1:0] mirror [MEM_WORDS]; // copy of what was loaded
  logic [15:0]            lfsr_state;

  // reference model
  logic             exp_valid;
  logic [PC_WD-1:0] exp_pc; // pc of the next item decode takes
  logic             hold_pending;
  fs_to_ds_t        held_bus;
  int unsigned      idle_cycles;
  int unsigned      stall_left;

  // how often each behavior was reached
  int unsigned n_items;
  int unsigned n_branches;
  int unsigned n_holds;
  int unsigned n_drains;

  fetch_top #(
    .P_RESET_PC       (RESET_PC  ),
    .P_ADDR_WD        (TB_ADDR_WD)
  ) dut0 (
    .i_clk            (clk       ),
    .i_arst_n         (arst_n    ),
    .i_br_bus         (br_bus    ),
    .i_ds_allowin     (ds_allowin),
    .o_fs_to_ds_valid (fs_valid  ),
    .o_fs_to_ds_bus   (fs_bus    ),
    .i_imem_we        (imem_we   ),
    .i_imem_waddr     (imem_waddr),
    .i_imem_wdata     (imem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("watchdog expired before the test sequence finished");
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one step per bit taken
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_reached(input string what, input int unsigned count);
    assert (count > 0)
      else report_failure($sformatf("stimulus never reached %s", what));
  endtask

  // instruction word at pc picked by bit 2
  function automatic logic [INST_WD-1:0] mirror_inst(input logic [PC_WD-1:0] pc);
    logic [MEM_DATA_WD-1:0] word;
    word = mirror[pc[DW_OFFSET +: TB_ADDR_WD]];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  // runs at the falling edge and looks at the cycle about to end
  task automatic check_cycle();
    assert (dut0.u_fetch_props.fail_cnt == 0)
      else report_failure("a bound property on the fetch outputs failed");
    check_value("o_fs_to_ds_valid", 64'(fs_valid), 64'(exp_valid));
    if (hold_pending) begin
      check_value("o_fs_to_ds_bus.pc", fs_bus.pc, held_bus.pc);
      check_value("o_fs_to_ds_bus.inst", 64'(fs_bus.inst), 64'(held_bus.inst));
    end
    if (fs_valid && ds_allowin) begin
      check_value("o_fs_to_ds_bus.pc", fs_bus.pc, exp_pc);
      check_value("o_fs_to_ds_bus.inst", 64'(fs_bus.inst), 64'(mirror_inst(exp_pc)));
      exp_pc      = exp_pc + PC_WD'(INST_BYTES);
      idle_cycles = 0;
      n_items++;
    end else begin
      idle_cycles++;
      assert (idle_cycles < IDLE_TIMEOUT)
        else report_failure("timeout, no item reached decode for too many cycles");
    end
    if (br_bus.sel) begin
      exp_pc = br_bus.target; // only driven with allowin high
      n_branches++;
    end
    if (fs_valid && !ds_allowin) n_holds++;
    if (br_bus.stall && fs_valid && ds_allowin) n_drains++;
    hold_pending = fs_valid && !ds_allowin;
    held_bus     = fs_bus;
    if (!fs_valid || ds_allowin) begin
      exp_valid = !br_bus.stall; // stage accepts when empty or drained
    end
  endtask

  task automatic pick_inputs(output logic allow_n, output br_bus_t bus_n);
    logic [63:0] r;
    bus_n = '0;
    take_bits(2, r);
    allow_n = (r[1:0] != 2'b00);
    if (stall_left > 0) begin
      stall_left--;
      bus_n.stall = 1'b1;
    end else begin
      take_bits(4, r);
      bus_n.stall = (r[3:0] == 4'h0);
      if (bus_n.stall) begin
        take_bits(2, r);
        stall_left = 2 + r[1:0]; // stalls of 3 to 6 cycles
      end
    end
    // branch pulses only with allowin high and no stall
    if (allow_n && !bus_n.stall) begin
      take_bits(3, r);
      if (r[2:0] == 3'h0) begin
        take_bits(8, r);
        bus_n.sel    = 1'b1;
        bus_n.target = RESET_PC + PC_WD'({r[7:0], 2'b00});
      end
    end
  endtask

  initial begin
    logic [63:0] w;
    logic        allow_n;
    br_bus_t     bus_n;
    int unsigned i;
    int unsigned wait_cnt;

    arst_n       = 1'b0;
    br_bus       = '0;
    br_bus.stall = 1'b1; // hold fetch off until the program is in
    ds_allowin   = 1'b0;
    imem_we      = 1'b0;
    imem_waddr   = '0;
    imem_wdata   = '0;
    lfsr_state   = LFSR_SEED;
    exp_valid    = 1'b0;
    exp_pc       = RESET_PC;
    hold_pending = 1'b0;
    held_bus     = '0;
    idle_cycles  = 0;
    stall_left   = 0;
    n_items      = 0;
    n_branches   = 0;
    n_holds      = 0;
    n_drains     = 0;

    // program load starts during reset
    for (i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      take_bits(64, w);
      mirror[i]  = w;
      imem_we    <= 1'b1;
      imem_waddr <= TB_ADDR_WD'(i);
      imem_wdata <= w;
      if (i == RESET_CYCLES) arst_n <= 1'b1;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    @(negedge clk);
    check_value("o_fs_to_ds_valid", 64'(fs_valid), 64'h0);

    // release the stall while decode still holds off
    @(posedge clk);
    br_bus <= '0;
    wait_cnt = 0;
    do begin
      @(negedge clk);
      check_cycle();
      wait_cnt++;
    end while (!fs_valid && wait_cnt < FIRST_TIMEOUT);
    assert (fs_valid) else report_failure("timeout waiting for the first fetched item");
    check_value("o_fs_to_ds_bus.pc", fs_bus.pc, RESET_PC);

    for (i = 0; i < RUN_CYCLES; i++) begin
      @(posedge clk);
      pick_inputs(allow_n, bus_n);
      ds_allowin <= allow_n;
      br_bus     <= bus_n;
      @(negedge clk);
      check_cycle();
    end

    check_reached("an item taken by decode", n_items);
    check_reached("a branch redirect", n_branches);
    check_reached("back-pressure", n_holds);
    check_reached("a drain under stall", n_drains);

    @(negedge clk); // lets the last property evaluation land
    if (dut0.u_fetch_props.fail_cnt != 0) begin
      report_failure("a bound property on the fetch outputs failed");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule : fetch_tb

`default_nettype wire

// ==== fetch_top.sv ====
// top of the fetch block, wires pc_gen, inst_rom and fetch_stage; instantiated by the testbench
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_params_pkg::*;
  import fetch_bus_pkg::*;
#(
  parameter logic [PC_WD-1:0] P_RESET_PC = RESET_PC,
  parameter int unsigned      P_ADDR_WD  = MEM_ADDR_WD
) (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // decode side
  input  br_bus_t                i_br_bus,
  input  logic                   i_ds_allowin,
  output logic                   o_fs_to_ds_valid,
  output fs_to_ds_t              o_fs_to_ds_bus,
  // memory load port
  input  logic                   i_imem_we,
  input  logic [P_ADDR_WD-1:0]   i_imem_waddr,
  input  logic [MEM_DATA_WD-1:0] i_imem_wdata
);

  logic                   load;
  logic [PC_WD-1:0]       fs_pc;
  imem_req_t              imem_req;
  logic [MEM_DATA_WD-1:0] imem_rdata;

  pc_gen #(
    .P_RESET_PC       (P_RESET_PC      ),
    .P_ADDR_WD        (P_ADDR_WD       )
  ) u_pc_gen (
    .i_clk            (i_clk           ),
    .i_arst_n         (i_arst_n        ),
    .i_load           (load            ),
    .i_br_bus         (i_br_bus        ), // redirect from decode
    .o_pc             (fs_pc           ),
    .o_imem_req       (imem_req        )
  );

  inst_rom #(
    .P_ADDR_WD        (P_ADDR_WD       )
  ) u_inst_rom (
    .i_clk            (i_clk           ),
    .i_imem_req       (imem_req        ),
    .i_we             (i_imem_we       ),
    .i_waddr          (i_imem_waddr    ),
    .i_wdata          (i_imem_wdata    ),
    .o_rdata          (imem_rdata      )
  );

  fetch_stage u_fetch_stage (
    .i_clk            (i_clk           ),
    .i_arst_n         (i_arst_n        ),
    .i_br_bus         (i_br_bus        ),
    .i_ds_allowin     (i_ds_allowin    ),
    .i_pc             (fs_pc           ),
    .i_rdata          (imem_rdata      ), // whole doubleword, half picked inside
    .o_load           (load            ),
    .o_fs_to_ds_valid (o_fs_to_ds_valid),
    .o_fs_to_ds_bus   (o_fs_to_ds_bus  )
  );

endmodule : fetch_top

`default_nettype wire

// ==== inst_rom.sv ====
// synchronous doubleword instruction memory with a plain load port, read side used by fetch_top
`timescale 1ns/1ps
`default_nettype none

module inst_rom
  import fetch_params_pkg::*;
  import fetch_bus_pkg::*;
#(
  parameter int unsigned P_ADDR_WD = MEM_ADDR_WD // depth is 2**P_ADDR_WD doublewords
) (
  input  logic                   i_clk,
  // read request from pc_gen
  input  imem_req_t              i_imem_req,
  // load port, written by the testbench before fetching starts
  input  logic                   i_we,
  input  logic [P_ADDR_WD-1:0]   i_waddr,
  input  logic [MEM_DATA_WD-1:0] i_wdata,
  // registered read data
  output logic [MEM_DATA_WD-1:0] o_rdata
);

  localparam int unsigned DEPTH = 2 ** P_ADDR_WD;

  logic [MEM_DATA_WD-1:0] mem [DEPTH];
  logic [MEM_DATA_WD-1:0] rdata_q;
  logic [P_ADDR_WD-1:0]   raddr;

  // upper index bits are zero when the memory is shallower than the bus
  assign raddr = i_imem_req.addr[P_ADDR_WD-1:0];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // read register moves only on ren
  // keeps the instruction steady while decode holds off
  always_ff @(posedge i_clk) begin
    if (i_imem_req.ren) begin
      rdata_q <= mem[raddr]; // old data on a same-cycle write
    end
  end

  assign o_rdata = rdata_q;

endmodule : inst_rom

`default_nettype wire

// ==== pc_gen.sv ====
// program counter register with next-pc select; drives the instruction memory read, used in fetch_top
`timescale 1ns/1ps
`default_nettype none

module pc_gen
  import fetch_params_pkg::*;
  import fetch_bus_pkg::*;
#(
  parameter logic [PC_WD-1:0] P_RESET_PC = RESET_PC,
  parameter int unsigned      P_ADDR_WD  = MEM_ADDR_WD // must not exceed MEM_ADDR_WD
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  // advance strobe from fetch_stage
  input  logic             i_load,
  // branch redirect from decode
  input  br_bus_t          i_br_bus,
  // current fetch pc
  output logic [PC_WD-1:0] o_pc,
  // instruction memory read
  output imem_req_t        o_imem_req
);

  logic [PC_WD-1:0]     pc_q;
  logic [PC_WD-1:0]     seq_pc;
  logic [PC_WD-1:0]     next_pc;
  logic [P_ADDR_WD-1:0] next_idx;

  // sequential fetch, no compressed instructions
  assign seq_pc = pc_q + PC_WD'(INST_BYTES);

  // decode resolves branches, so a taken branch simply overrides pc + 4
  always_comb begin
    if (i_br_bus.sel) begin
      next_pc = i_br_bus.target;
    end else begin
      next_pc = seq_pc;
    end
  end

  // start one step early so the first load lands on the reset vector
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= P_RESET_PC - PC_WD'(INST_BYTES);
    end else if (i_load) begin
      pc_q <= next_pc;
    end
  end

  assign o_pc = pc_q;

  // doubleword index of the pc being loaded
  // bits above the memory depth wrap, the upper pc bits are ignored
  assign next_idx = next_pc[DW_OFFSET +: P_ADDR_WD];

  // read issued in the same cycle as the load, data is back with the new pc
  always_comb begin
    o_imem_req      = '0;
    o_imem_req.ren  = i_load;
    o_imem_req.addr = MEM_ADDR_WD'(next_idx); // zero extend for a shallow memory
  end

endmodule : pc_gen

`default_nettype wire

// ==== sources.f ====
fetch_params_pkg.sv
fetch_bus_pkg.sv
pc_gen.sv
inst_rom.sv
fetch_stage.sv
fetch_top.sv
fetch_props.sv
fetch_tb.sv
